//--- src.f
+incdir+rtl
rtl/mem_pipe_pkg.sv
rtl/dtlb_lookup.sv
rtl/cp0_exc_regs.sv
rtl/m1_stage.sv
rtl/data_sram.sv
rtl/ms_stage.sv
rtl/mem_pipe_top.sv
sim/mem_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the memory pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mem_pipe_tb -f src.f -o mem_pipe_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/mem_pipe_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim/mem_pipe_tb.sv
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module mem_pipe_tb;
    import mem_pipe_pkg::*;

    localparam int N_DIRECTED  = 60;                 // upper bound, directed tests
    localparam int N_RANDOM    = 200;
    localparam int CYCLE_LIMIT = 200 + 12 * (N_DIRECTED + N_RANDOM);

    typedef struct {
        logic [31:0] pc;
        mem_op_e     op;
        logic [31:0] data;
        exc_code_e   code;
        logic        ex;
        logic [31:0] epc;
        logic [31:0] badv;
        logic        exl;
        int          acc;                            // cycle of acceptance
        logic        chk_lat;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid, in_allowin, in_ex;
    mem_op_e               in_op;
    logic [31:0]           in_pc, in_addr, in_wdata;
    logic                  out_valid, out_ex;
    logic                  out_ready = 1'b1;
    logic [31:0]           out_pc, out_data;
    mem_op_e               out_op;
    exc_code_e             out_exccode;
    logic                  tlb_we, tlb_v, tlb_d;
    logic [`TLB_IDX_W-1:0] tlb_index;
    logic [19:0]           tlb_vpn, tlb_pfn;
    logic                  flush, exl;
    logic [31:0]           flush_target, epc, badvaddr;

    logic [7:0]  mem_ref [1024];                     // byte image of the SRAM
    logic [19:0] t_vpn [`TLB_ENTRIES];
    logic [19:0] t_pfn [`TLB_ENTRIES];
    logic        t_v [`TLB_ENTRIES];
    logic        t_d [`TLB_ENTRIES];
    logic [31:0] m_epc = '0;
    logic [31:0] m_badv = '0;
    logic        m_exl = 1'b0;
    logic [31:0] next_pc = 32'h0000_1000;
    exp_t        exp_q [$];
    logic [31:0] flush_q [$];                        // pending flush targets
    int          cycle = 0;
    int          errors = 0;
    int          misc_errs = 0;
    int          last_total = 0;
    int          checked = 0;
    int          both_full = 0;
    int          seed = 71;
    int          ready_seed = 71;
    logic        rand_ready = 1'b0;

    mem_pipe_top u_dut (.*);

    always #2 clk = ~clk;

    always @(negedge clk) begin
        cycle++;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        out_ready <= rand_ready ? 1'($random(ready_seed)) : 1'b1;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, want, got);
            errors++;
        end
    endtask

    // outputs and exception registers at each handshake, targets at each flush
    always @(posedge clk) begin
        exp_t e;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output at %0t with pc %h was never issued", $time, out_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checked++;
                compare_field("out_pc", out_pc, e.pc);
                compare_field("out_op", 32'(out_op), 32'(e.op));
                compare_field("out_data", out_data, e.data);
                compare_field("out_exccode", 32'(out_exccode), 32'(e.code));
                compare_field("out_ex", 32'(out_ex), 32'(e.ex));
                compare_field("epc", epc, e.epc);
                compare_field("badvaddr", badvaddr, e.badv);
                compare_field("exl", 32'(exl), 32'(e.exl));
                if (e.chk_lat) begin
                    compare_field("out_valid latency", 32'(cycle - e.acc), 32'd2);
                end
            end
        end
        if (!reset && flush) begin
            if (flush_q.size() == 0) begin
                $display("flush at %0t with no exception or eret leaving", $time);
                errors++;
            end else begin
                compare_field("flush_target", flush_target, flush_q.pop_front());
            end
        end
        if (!reset && out_valid && !out_ready && !in_allowin) begin
            both_full++;                             // m1 and ms both occupied
        end
    end

    reset_state: assert property (@(posedge clk)
            $fell(reset) |-> (in_allowin && !out_valid && !flush && !exl))
        else begin
            $display("state after reset is wrong at %0t", $time);
            errors++;
        end
    flush_blocks_entry: assert property (@(posedge clk) disable iff (reset)
            flush |-> !in_allowin)
        else begin
            $display("in_allowin was high during a flush at %0t", $time);
            errors++;
        end
    exc_sets_exl: assert property (@(posedge clk) disable iff (reset)
            (flush && flush_target == `EXC_VECTOR) |=> exl)
        else begin
            $display("exl not set after an exception flush at %0t", $time);
            errors++;
        end
    eret_clears_exl: assert property (@(posedge clk) disable iff (reset)
            (flush && flush_target != `EXC_VECTOR) |=> !exl)
        else begin
            $display("exl still set after eret at %0t", $time);
            errors++;
        end

    task automatic predict(input mem_op_e op, input logic [31:0] pc, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic ex);
        exp_t        e;
        logic        is_ld, is_st, mis, ok, dirty;
        logic [31:0] paddr;
        logic [9:0]  pa;
        logic [7:0]  b0, b1, b2, b3;
        is_ld = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
        is_st = op inside {op_sb, op_sh, op_sw};
        mis   = ((op inside {op_lh, op_lhu, op_sh}) && addr[0]) ||
                ((op inside {op_lw, op_sw}) && addr[1:0] != 2'b00);
        ok    = 1'b0;
        dirty = 1'b0;
        paddr = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (t_vpn[i] == addr[31:12]) begin
                ok    = t_v[i];
                dirty = t_d[i];
                paddr = {t_pfn[i], addr[11:0]};
            end
        end
        pa = paddr[`DSRAM_AW+1:0];
        e.data = '0;
        if (ex) e.code = exc_ri;
        else if (mis) e.code = is_st ? exc_ades : exc_adel;
        else if ((is_ld || is_st) && !ok) e.code = is_st ? exc_tlbs : exc_tlbl;
        else if (is_st && !dirty) e.code = exc_mod;
        else e.code = exc_none;
        if (e.code == exc_none) begin
            b0 = mem_ref[pa];
            b1 = mem_ref[pa + 10'd1];
            b2 = mem_ref[pa + 10'd2];
            b3 = mem_ref[pa + 10'd3];
            case (op)
                op_sb:   mem_ref[pa] = wdata[7:0];
                op_sh: begin
                    mem_ref[pa]         = wdata[7:0];
                    mem_ref[pa + 10'd1] = wdata[15:8];
                end
                op_sw: for (int k = 0; k < 4; k++) mem_ref[pa + 10'(k)] = wdata[8*k +: 8];
                op_lb:   e.data = {{24{b0[7]}}, b0};
                op_lbu:  e.data = {24'd0, b0};
                op_lh:   e.data = {{16{b1[7]}}, b1, b0};
                op_lhu:  e.data = {16'd0, b1, b0};
                op_lw:   e.data = {b3, b2, b1, b0};
                op_eret: begin
                    flush_q.push_back(m_epc);        // return to saved pc
                    m_exl = 1'b0;
                end
                default: ;
            endcase
        end else begin
            flush_q.push_back(`EXC_VECTOR);
            if (!m_exl) m_epc = pc;                  // nested fault keeps first pc
            m_exl = 1'b1;
            if (!ex) m_badv = addr;
        end
        e.pc      = pc;
        e.op      = op;
        e.ex      = e.code != exc_none;
        e.epc     = m_epc;
        e.badv    = m_badv;
        e.exl     = m_exl;
        e.acc     = cycle;
        e.chk_lat = !rand_ready;
        exp_q.push_back(e);
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic ex);
        logic taken;
        in_valid = 1'b1;
        in_op    = op;
        in_pc    = next_pc;
        in_addr  = addr;
        in_wdata = wdata;
        in_ex    = ex;
        taken    = 1'b0;
        while (!taken) begin
            #1;
            taken = in_allowin;
            @(posedge clk);
            if (taken) predict(op, next_pc, addr, wdata, ex);
            @(negedge clk);
        end
        next_pc  = next_pc + 32'd4;
        in_valid = 1'b0;
    endtask

    task automatic tlb_write(input logic [`TLB_IDX_W-1:0] idx, input logic [19:0] vpn,
                             input logic [19:0] pfn, input logic v, input logic d);
        tlb_we     = 1'b1;
        tlb_index  = idx;
        tlb_vpn    = vpn;
        tlb_pfn    = pfn;
        tlb_v      = v;
        tlb_d      = d;
        t_vpn[idx] = vpn;
        t_pfn[idx] = pfn;
        t_v[idx]   = v;
        t_d[idx]   = d;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %s: done, %0d errors", name, errors + misc_errs - last_total);
        last_total = errors + misc_errs;
    endtask

    initial begin
        logic [31:0] r;
        logic [19:0] vpn;
        in_valid  = 1'b0;
        in_op     = op_none;
        in_pc     = '0;
        in_addr   = '0;
        in_wdata  = '0;
        in_ex     = 1'b0;
        tlb_we    = 1'b0;
        tlb_index = '0;
        tlb_vpn   = '0;
        tlb_pfn   = '0;
        tlb_v     = 1'b0;
        tlb_d     = 1'b0;
        reset     = 1'b1;
        for (int i = 0; i < 1024; i++) mem_ref[i] = 8'h00;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            t_vpn[i] = '0;
            t_pfn[i] = '0;
            t_v[i]   = 1'b0;
            t_d[i]   = 1'b0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;

        tlb_write(2'd0, 20'h00400, 20'h00010, 1'b1, 1'b1);
        tlb_write(2'd1, 20'h00401, 20'h00020, 1'b1, 1'b1);
        issue(op_sw, 32'h0040_0010, 32'h8765_43a1, 1'b0);
        issue(op_sh, 32'h0040_0014, 32'h0000_beef, 1'b0);
        issue(op_sh, 32'h0040_0016, 32'h1234_7f0d, 1'b0);
        for (int k = 0; k < 4; k++) issue(op_sb, 32'h0040_0018 + 32'(k), $random(seed), 1'b0);
        issue(op_sw, 32'h0040_1020, 32'h1357_9bdf, 1'b0);
        issue(op_lw, 32'h0040_0010, 32'h0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            issue(op_lb, 32'h0040_0010 + 32'(k), 32'h0, 1'b0);
            issue(op_lbu, 32'h0040_0010 + 32'(k), 32'h0, 1'b0);
        end
        issue(op_lh, 32'h0040_0014, 32'h0, 1'b0);
        issue(op_lhu, 32'h0040_0014, 32'h0, 1'b0);
        issue(op_lh, 32'h0040_0016, 32'h0, 1'b0);
        issue(op_lhu, 32'h0040_0016, 32'h0, 1'b0);
        issue(op_lw, 32'h0040_0018, 32'h0, 1'b0);
        issue(op_lw, 32'h0040_1020, 32'h0, 1'b0);
        issue(op_lh, 32'h0040_1022, 32'h0, 1'b0);
        drain();
        report_test("mapped stores and loads");

        issue(op_lh, 32'h0040_0011, 32'h0, 1'b0);
        issue(op_lw, 32'h0040_0012, 32'h0, 1'b0);
        issue(op_sh, 32'h0040_0015, 32'h0000_dead, 1'b0);
        issue(op_sw, 32'h0040_0013, 32'hffff_ffff, 1'b0);
        issue(op_lw, 32'h0040_0014, 32'h0, 1'b0);     // memory untouched by the faults
        issue(op_lw, 32'h0040_0010, 32'h0, 1'b0);
        issue(op_eret, 32'h0, 32'h0, 1'b0);
        drain();
        report_test("misaligned access");

        issue(op_lw, 32'h0050_0000, 32'h0, 1'b0);
        issue(op_sw, 32'h0050_0004, 32'h1111_2222, 1'b0);
        drain();
        tlb_write(2'd2, 20'h00402, 20'h00030, 1'b0, 1'b1);
        issue(op_lw, 32'h0040_2008, 32'h0, 1'b0);
        issue(op_sb, 32'h0040_2009, 32'h0000_0055, 1'b0);
        drain();
        tlb_write(2'd3, 20'h00403, 20'h00031, 1'b1, 1'b0);
        issue(op_sw, 32'h0040_3040, 32'hcafe_f00d, 1'b0);
        issue(op_lw, 32'h0040_3040, 32'h0, 1'b0);
        issue(op_lw, 32'h0040_0010, 32'h0, 1'b1);
        issue(op_sw, 32'h0040_0011, 32'h0, 1'b1);     // carried beats misalignment
        issue(op_eret, 32'h0, 32'h0, 1'b0);
        drain();
        report_test("tlb and carried exceptions");

        issue(op_lw, 32'h0040_0011, 32'h0, 1'b0);
        issue(op_sw, 32'h0050_0000, 32'h0, 1'b0);
        issue(op_lb, 32'h0040_0010, 32'h0, 1'b0);
        issue(op_eret, 32'h0, 32'h0, 1'b0);
        issue(op_lhu, 32'h0040_0013, 32'h0, 1'b0);
        issue(op_eret, 32'h0, 32'h0, 1'b0);
        issue(op_eret, 32'h0, 32'h0, 1'b0);
        drain();
        report_test("epc and eret");

        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            case (r[6:4])
                3'd0, 3'd4, 3'd5: vpn = 20'h00400;
                3'd1, 3'd6:       vpn = 20'h00401;
                3'd2:             vpn = 20'h00402;
                3'd3:             vpn = 20'h00403;
                default:          vpn = 20'h00500;
            endcase
            issue(mem_op_e'(4'(32'd1 + (r % 32'd9))),
                  {vpn, 4'b0000, r[13:8], (r[19:18] == 2'b00) ? r[21:20] : 2'b00},
                  $random(seed), r[25:22] == 4'd0);
        end
        drain();
        rand_ready = 1'b0;
        assert (both_full > 0) else begin
            $display("back-pressure never filled both stages");
            misc_errs++;
        end
        report_test("random back-pressure");

        assert (flush_q.size() == 0) else begin
            $display("%0d expected flushes never happened", flush_q.size());
            misc_errs++;
        end
        $display("summary: %0d outputs checked, %0d errors", checked, errors + misc_errs);
        if (errors + misc_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/mem_pipe_top.sv
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module mem_pipe_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_allowin,
    input  mem_pipe_pkg::mem_op_e   in_op,
    input  logic [31:0]             in_pc,
    input  logic [31:0]             in_addr,
    input  logic [31:0]             in_wdata,
    input  logic                    in_ex,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [31:0]             out_pc,
    output mem_pipe_pkg::mem_op_e   out_op,
    output logic [31:0]             out_data,
    output mem_pipe_pkg::exc_code_e out_exccode,
    output logic                    out_ex,
    input  logic                    tlb_we,
    input  logic [`TLB_IDX_W-1:0]   tlb_index,
    input  logic [19:0]             tlb_vpn,
    input  logic [19:0]             tlb_pfn,
    input  logic                    tlb_v,
    input  logic                    tlb_d,
    output logic                    flush,
    output logic [31:0]             flush_target,
    output logic [31:0]             epc,
    output logic [31:0]             badvaddr,
    output logic                    exl
);

    logic [19:0]             lk_vpn;
    logic                    lk_hit;
    logic [19:0]             lk_pfn;
    logic                    lk_v;
    logic                    lk_d;
    logic                    sram_en;
    logic [3:0]              sram_we;
    logic [`DSRAM_AW-1:0]    sram_addr;
    logic [31:0]             sram_wdata;
    logic [31:0]             sram_rdata;
    logic                    exc_commit;
    mem_pipe_pkg::exc_code_e exc_code;
    logic [31:0]             exc_pc;
    logic [31:0]             exc_badvaddr;
    logic                    exc_badv_we;
    logic                    eret_commit;
    logic                    ms_allowin;
    logic                    m1_to_ms_valid;
    mem_pipe_pkg::mem_op_e   m1_to_ms_op;
    logic [31:0]             m1_to_ms_pc;
    logic [1:0]              m1_to_ms_offset;
    mem_pipe_pkg::exc_code_e m1_to_ms_code;
    logic                    m1_to_ms_ex;

    m1_stage u_m1_stage (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_op           (in_op),
        .in_pc           (in_pc),
        .in_addr         (in_addr),
        .in_wdata        (in_wdata),
        .in_ex           (in_ex),
        .ms_allowin      (ms_allowin),
        .tlb_vpn         (lk_vpn),
        .tlb_hit         (lk_hit),
        .tlb_pfn         (lk_pfn),
        .tlb_v           (lk_v),
        .tlb_d           (lk_d),
        .sram_en         (sram_en),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .exc_commit      (exc_commit),
        .exc_code        (exc_code),
        .exc_pc          (exc_pc),
        .exc_badvaddr    (exc_badvaddr),
        .exc_badv_we     (exc_badv_we),
        .eret_commit     (eret_commit),
        .exc_epc         (epc),
        .flush           (flush),
        .flush_target    (flush_target),
        .m1_to_ms_valid  (m1_to_ms_valid),
        .m1_to_ms_op     (m1_to_ms_op),
        .m1_to_ms_pc     (m1_to_ms_pc),
        .m1_to_ms_offset (m1_to_ms_offset),
        .m1_to_ms_code   (m1_to_ms_code),
        .m1_to_ms_ex     (m1_to_ms_ex)
    );

    dtlb_lookup u_dtlb_lookup (
        .clk       (clk),
        .reset     (reset),
        .tlb_we    (tlb_we),
        .tlb_index (tlb_index),
        .tlb_vpn_w (tlb_vpn),
        .tlb_pfn_w (tlb_pfn),
        .tlb_v_w   (tlb_v),
        .tlb_d_w   (tlb_d),
        .vpn       (lk_vpn),
        .hit       (lk_hit),
        .pfn       (lk_pfn),
        .v         (lk_v),
        .d         (lk_d)
    );

    cp0_exc_regs u_cp0_exc_regs (
        .clk          (clk),
        .reset        (reset),
        .exc_commit   (exc_commit),
        .exc_code     (exc_code),
        .exc_pc       (exc_pc),
        .exc_badvaddr (exc_badvaddr),
        .exc_badv_we  (exc_badv_we),
        .eret_commit  (eret_commit),
        .epc          (epc),
        .badvaddr     (badvaddr),
        .exccode      (),                // stored code not exported
        .exl          (exl)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .reset (reset),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    ms_stage u_ms_stage (
        .clk         (clk),
        .reset       (reset),
        .m1_valid    (m1_to_ms_valid),
        .m1_op       (m1_to_ms_op),
        .m1_pc       (m1_to_ms_pc),
        .m1_offset   (m1_to_ms_offset),
        .m1_code     (m1_to_ms_code),
        .m1_ex       (m1_to_ms_ex),
        .sram_rdata  (sram_rdata),
        .out_ready   (out_ready),
        .ms_allowin  (ms_allowin),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_op      (out_op),
        .out_data    (out_data),
        .out_exccode (out_exccode),
        .out_ex      (out_ex)
    );

endmodule

//--- rtl/ms_stage.sv
`timescale 1ns/1ps

module ms_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    m1_valid,
    input  mem_pipe_pkg::mem_op_e   m1_op,
    input  logic [31:0]             m1_pc,
    input  logic [1:0]              m1_offset,
    input  mem_pipe_pkg::exc_code_e m1_code,
    input  logic                    m1_ex,
    input  logic [31:0]             sram_rdata,
    input  logic                    out_ready,
    output logic                    ms_allowin,
    output logic                    out_valid,
    output logic [31:0]             out_pc,
    output mem_pipe_pkg::mem_op_e   out_op,
    output logic [31:0]             out_data,
    output mem_pipe_pkg::exc_code_e out_exccode,
    output logic                    out_ex
);
    import mem_pipe_pkg::*;

    logic        ms_valid;
    logic        ms_fresh;
    logic [1:0]  ms_offset;
    logic [31:0] rdata_q;
    logic [31:0] raw;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign ms_allowin = ~ms_valid | out_ready;
    assign out_valid  = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
            ms_fresh <= 1'b0;
        end else begin
            if (ms_allowin) begin
                ms_valid <= m1_valid;
            end
            ms_fresh <= m1_valid & ms_allowin;     // first cycle after entry
        end
    end

    always_ff @(posedge clk) begin
        if (m1_valid && ms_allowin) begin
            out_op      <= m1_op;
            out_pc      <= m1_pc;
            ms_offset   <= m1_offset;
            out_exccode <= m1_code;
            out_ex      <= m1_ex;
        end
        if (ms_fresh) begin
            rdata_q <= sram_rdata;                 // keep data over a stall
        end
    end

    assign raw     = ms_fresh ? sram_rdata : rdata_q;
    assign ld_byte = raw[{ms_offset, 3'b000} +: 8];
    assign ld_half = ms_offset[1] ? raw[31:16] : raw[15:0];

    always_comb begin
        case (out_ex ? op_none : out_op)
            op_lb:   out_data = {{24{ld_byte[7]}}, ld_byte};
            op_lbu:  out_data = {24'd0, ld_byte};
            op_lh:   out_data = {{16{ld_half[15]}}, ld_half};
            op_lhu:  out_data = {16'd0, ld_half};
            op_lw:   out_data = raw;
            default: out_data = '0;                // stores, eret, faults
        endcase
    end

endmodule

//--- rtl/data_sram.sv
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module data_sram (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic [3:0]           we,
    input  logic [`DSRAM_AW-1:0] addr,
    input  logic [31:0]          wdata,
    output logic [31:0]          rdata
);

    logic [31:0] mem [`DSRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DSRAM_DEPTH; i++) begin
                mem[i] <= '0;                    // memory starts zeroed
            end
            rdata <= '0;
        end else if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            if (we == 4'b0000) begin
                rdata <= mem[addr];              // read only, held otherwise
            end
        end
    end

endmodule

//--- rtl/m1_stage.sv
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module m1_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_allowin,
    input  mem_pipe_pkg::mem_op_e   in_op,
    input  logic [31:0]             in_pc,
    input  logic [31:0]             in_addr,
    input  logic [31:0]             in_wdata,
    input  logic                    in_ex,
    input  logic                    ms_allowin,
    output logic [19:0]             tlb_vpn,
    input  logic                    tlb_hit,
    input  logic [19:0]             tlb_pfn,
    input  logic                    tlb_v,
    input  logic                    tlb_d,
    output logic                    sram_en,
    output logic [3:0]              sram_we,
    output logic [`DSRAM_AW-1:0]    sram_addr,
    output logic [31:0]             sram_wdata,
    output logic                    exc_commit,
    output mem_pipe_pkg::exc_code_e exc_code,
    output logic [31:0]             exc_pc,
    output logic [31:0]             exc_badvaddr,
    output logic                    exc_badv_we,
    output logic                    eret_commit,
    input  logic [31:0]             exc_epc,
    output logic                    flush,
    output logic [31:0]             flush_target,
    output logic                    m1_to_ms_valid,
    output mem_pipe_pkg::mem_op_e   m1_to_ms_op,
    output logic [31:0]             m1_to_ms_pc,
    output logic [1:0]              m1_to_ms_offset,
    output mem_pipe_pkg::exc_code_e m1_to_ms_code,
    output logic                    m1_to_ms_ex
);
    import mem_pipe_pkg::*;

    logic        m1_valid;
    mem_op_e     m1_op;
    logic [31:0] m1_pc;
    logic [31:0] m1_addr;
    logic [31:0] m1_wdata;
    logic        m1_carried;
    logic        is_load;
    logic        is_store;
    logic        misaligned;
    logic        has_exc;
    logic        leaving;
    logic [3:0]  strobe;
    logic [31:0] paddr;

    assign leaving    = m1_valid & ms_allowin;
    assign flush      = exc_commit | eret_commit;
    assign in_allowin = (~m1_valid | ms_allowin) & ~flush;   // no entry while flushing

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (in_allowin) begin
            m1_valid <= in_valid;
        end else if (ms_allowin) begin
            m1_valid <= 1'b0;                                 // faulting instr left
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            m1_op      <= in_op;
            m1_pc      <= in_pc;
            m1_addr    <= in_addr;
            m1_wdata   <= in_wdata;
            m1_carried <= in_ex;
        end
    end

    assign is_load  = m1_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    assign is_store = m1_op inside {op_sb, op_sh, op_sw};
    assign tlb_vpn  = m1_addr[31:12];
    assign paddr    = {tlb_pfn, m1_addr[11:0]};

    always_comb begin
        case (m1_op)
            op_lh, op_lhu, op_sh: misaligned = m1_addr[0];
            op_lw, op_sw:         misaligned = |m1_addr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    // carried first, then alignment, TLB, dirty bit
    always_comb begin
        if (m1_carried) begin
            exc_code = exc_ri;
        end else if (misaligned) begin
            exc_code = is_store ? exc_ades : exc_adel;
        end else if ((is_load || is_store) && !(tlb_hit && tlb_v)) begin
            exc_code = is_store ? exc_tlbs : exc_tlbl;
        end else if (is_store && !tlb_d) begin
            exc_code = exc_mod;
        end else begin
            exc_code = exc_none;
        end
    end

    assign has_exc      = exc_code != exc_none;
    assign exc_commit   = leaving & has_exc;
    assign eret_commit  = leaving & ~has_exc & (m1_op == op_eret);
    assign exc_badv_we  = exc_commit & ~m1_carried;
    assign exc_pc       = m1_pc;
    assign exc_badvaddr = m1_addr;
    assign flush_target = exc_commit ? `EXC_VECTOR : exc_epc;

    // byte lanes and replicated store data
    always_comb begin
        case (m1_op)
            op_sb: begin
                strobe     = 4'b0001 << m1_addr[1:0];
                sram_wdata = {4{m1_wdata[7:0]}};
            end
            op_sh: begin
                strobe     = m1_addr[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{m1_wdata[15:0]}};
            end
            default: begin
                strobe     = {4{is_store}};
                sram_wdata = m1_wdata;
            end
        endcase
    end

    assign sram_en   = leaving & ~has_exc & (is_load | is_store);
    assign sram_we   = sram_en ? strobe : 4'b0000;
    assign sram_addr = paddr[`DSRAM_AW+1:2];

    assign m1_to_ms_valid  = m1_valid;
    assign m1_to_ms_op     = m1_op;
    assign m1_to_ms_pc     = m1_pc;
    assign m1_to_ms_offset = m1_addr[1:0];
    assign m1_to_ms_code   = exc_code;
    assign m1_to_ms_ex     = has_exc;

endmodule

//--- rtl/cp0_exc_regs.sv
`timescale 1ns/1ps

module cp0_exc_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    exc_commit,
    input  mem_pipe_pkg::exc_code_e exc_code,
    input  logic [31:0]             exc_pc,
    input  logic [31:0]             exc_badvaddr,
    input  logic                    exc_badv_we,
    input  logic                    eret_commit,
    output logic [31:0]             epc,
    output logic [31:0]             badvaddr,
    output mem_pipe_pkg::exc_code_e exccode,
    output logic                    exl
);
    import mem_pipe_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            epc      <= '0;
            badvaddr <= '0;
            exccode  <= exc_none;
            exl      <= 1'b0;
        end else begin
            if (exc_commit) begin
                exccode <= exc_code;
                exl     <= 1'b1;
                if (!exl) begin
                    epc <= exc_pc;            // nested fault keeps first pc
                end
            end else if (eret_commit) begin
                exl <= 1'b0;
            end
            if (exc_badv_we) begin
                badvaddr <= exc_badvaddr;     // address and TLB faults only
            end
        end
    end

endmodule

//--- rtl/dtlb_lookup.sv
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module dtlb_lookup (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tlb_we,
    input  logic [`TLB_IDX_W-1:0] tlb_index,
    input  logic [19:0]           tlb_vpn_w,
    input  logic [19:0]           tlb_pfn_w,
    input  logic                  tlb_v_w,
    input  logic                  tlb_d_w,
    input  logic [19:0]           vpn,
    output logic                  hit,
    output logic [19:0]           pfn,
    output logic                  v,
    output logic                  d
);

    logic [19:0] vpn_q [`TLB_ENTRIES];
    logic [19:0] pfn_q [`TLB_ENTRIES];
    logic        v_q   [`TLB_ENTRIES];
    logic        d_q   [`TLB_ENTRIES];

    // entry write, seen by lookups from the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                vpn_q[i] <= '0;
                pfn_q[i] <= '0;
                v_q[i]   <= 1'b0;
                d_q[i]   <= 1'b0;
            end
        end else if (tlb_we) begin
            vpn_q[tlb_index] <= tlb_vpn_w;
            pfn_q[tlb_index] <= tlb_pfn_w;
            v_q[tlb_index]   <= tlb_v_w;
            d_q[tlb_index]   <= tlb_d_w;
        end
    end

    // parallel compare against all entries
    always_comb begin
        hit = 1'b0;
        pfn = '0;
        v   = 1'b0;
        d   = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (vpn_q[i] == vpn) begin
                hit = 1'b1;
                pfn = pfn_q[i];
                v   = v_q[i];
                d   = d_q[i];
            end
        end
    end

endmodule

//--- rtl/mem_pipe_pkg.sv
package mem_pipe_pkg;

    // memory stage operations
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lbu  = 4'd2,
        op_lh   = 4'd3,
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8,
        op_eret = 4'd9
    } mem_op_e;

    // MIPS Cause.ExcCode numbering
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_mod  = 5'd1,   // store to clean page
        exc_tlbl = 5'd2,   // load miss / invalid
        exc_tlbs = 5'd3,   // store miss / invalid
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ri   = 5'd10   // carried from execute
    } exc_code_e;

endpackage

//--- rtl/mem_pipe_defines.svh
`ifndef MEM_PIPE_DEFINES_SVH
`define MEM_PIPE_DEFINES_SVH

// data SRAM geometry
`define DSRAM_AW 8                     // word address bits
`define DSRAM_DEPTH (1 << `DSRAM_AW)   // 256 words

// data TLB
`define TLB_ENTRIES 4
`define TLB_IDX_W 2                    // index into the entry array

// all exceptions vector here, eret goes back to EPC
`define EXC_VECTOR 32'hBFC0_0380

`endif
